/* include/core_consts.svh */
// core constants for the register port, the address map and the stream crossbar
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

`define CORE_REG_AWIDTH     14   // register address bits
`define CORE_REG_DWIDTH     32   // register data bits
`define CORE_DATA_WIDTH     64   // one stream beat

////////////////////////////////////////////////////////////
// crossbar sizing
////////////////////////////////////////////////////////////

// port order is eth0, eth1, dma, ce0
`define CORE_NUM_PORTS      4
`define CORE_ROUTE_ENTRIES  16   // indexed by the dest nibble

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////

`define REG_GIT_HASH        'h0   // build hash, read only
`define REG_NUM_CE          'h4   // engine count, read only
`define REG_SCRATCH         'h8   // read/write, drives spi mux and cpld reset
`define REG_XBAR_BASE       'h10  // first routing row, one row per word

// power-up value of scratch selects spi mux 2 with cpld out of reset
`define SCRATCH_RESET       'h2

// build identity words
`define CORE_GIT_HASH       32'h5d0e_a93c
`define CORE_NUM_CE         1

`endif

/* logic/core_reg_pkg.sv */
// register port types shared by the top level and the control block
`default_nettype none

`include "core_consts.svh"

package core_reg_pkg;

  ////////////////////////////////////////////////////////////
  // scalar words
  ////////////////////////////////////////////////////////////

  typedef logic [`CORE_REG_AWIDTH-1:0] reg_addr_t;  // byte address
  typedef logic [`CORE_REG_DWIDTH-1:0] reg_data_t;  // one register word

  ////////////////////////////////////////////////////////////
  // strobe bundles
  ////////////////////////////////////////////////////////////

  // write takes effect on the edge where wr_req is high
  typedef struct packed {
    logic      wr_req;  // one cycle per write
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

  // read request, one cycle strobe
  typedef struct packed {
    logic      rd_req;
    reg_addr_t addr;
  } reg_rd_req_t;

  // answer comes one cycle after the strobe
  typedef struct packed {
    logic      resp;    // single cycle pulse
    reg_data_t data;    // valid with resp only
  } reg_rd_resp_t;

endpackage

`default_nettype wire

/* logic/core_stream_pkg.sv */
// stream and routing types for the packet crossbar
`default_nettype none

`include "core_consts.svh"

package core_stream_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////

  typedef logic [`CORE_DATA_WIDTH-1:0] beat_data_t;  // one stream word

  // crossbar port number
  typedef logic [$clog2(`CORE_NUM_PORTS)-1:0] port_idx_t;

  // one bit per crossbar port, used for requests and grants
  typedef logic [`CORE_NUM_PORTS-1:0] port_mask_t;

  // low nibble of the dest field picks the routing row
  typedef logic [$clog2(`CORE_ROUTE_ENTRIES)-1:0] route_idx_t;

  // whole routing table, row k gives the output for dest nibble k
  typedef port_idx_t [`CORE_ROUTE_ENTRIES-1:0] route_table_t;

  ////////////////////////////////////////////////////////////
  // stream bundle
  ////////////////////////////////////////////////////////////

  // tready runs the other way so it is kept out
  typedef struct packed {
    logic       tvalid;
    logic       tlast;   // marks the final beat of a packet
    beat_data_t tdata;   // dest field sits in bits 15..0 of the header beat
  } stream_t;

  ////////////////////////////////////////////////////////////
  // input port FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    IDLE,     // waiting for a header beat
    ROUTED    // route latched, packet in flight
  } in_state_e;

endpackage

`default_nettype wire

/* logic/core_ctrl.sv */
// global registers, crossbar routing table and the merged register read path
`default_nettype none

`include "core_consts.svh"

module core_ctrl
  import core_reg_pkg::*;
  import core_stream_pkg::*;
(
  input  logic         bus_clk,
  input  logic         bus_rst,
  input  reg_wr_t      i_reg_wr,        // write strobe, addr, data
  input  reg_rd_req_t  i_reg_rd,        // read strobe, addr
  output reg_rd_resp_t o_reg_rd_resp,   // one cycle after the strobe
  output route_table_t o_route_table,   // to every input port
  output logic [2:0]   o_spi_mux,
  output logic         o_cpld_reset
);

  localparam reg_addr_t XBAR_BASE = reg_addr_t'(`REG_XBAR_BASE);
  localparam reg_addr_t XBAR_SPAN = reg_addr_t'(4 * `CORE_ROUTE_ENTRIES);  // bytes

  reg_data_t    scratch_reg;
  route_table_t route_tbl;
  logic         rd_glob_hit;    // global register addressed
  reg_data_t    rd_glob_data;
  logic         rd_xbar_hit;    // routing row addressed
  reg_data_t    rd_xbar_data;
  logic         rd_resp_q;
  reg_data_t    rd_data_q;

  // true for an aligned word inside the routing window
  function automatic logic xbar_hit(input reg_addr_t addr);
    reg_addr_t off;
    off = addr - XBAR_BASE;
    return (addr >= XBAR_BASE) && (off < XBAR_SPAN) && (off[1:0] == 2'b00);
  endfunction

  // row number inside the window
  function automatic route_idx_t xbar_row(input reg_addr_t addr);
    reg_addr_t off;
    off = addr - XBAR_BASE;
    return route_idx_t'(off >> 2);
  endfunction

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      scratch_reg <= reg_data_t'(`SCRATCH_RESET);
      for (int k = 0; k < `CORE_ROUTE_ENTRIES; k++) begin
        route_tbl[k] <= port_idx_t'(k % `CORE_NUM_PORTS);  // row k to port k mod 4
      end
    end else if (i_reg_wr.wr_req) begin
      if (i_reg_wr.addr == reg_addr_t'(`REG_SCRATCH)) begin
        scratch_reg <= i_reg_wr.data;
      end
      if (xbar_hit(i_reg_wr.addr)) begin
        route_tbl[xbar_row(i_reg_wr.addr)] <= i_reg_wr.data[$bits(port_idx_t)-1:0];  // low bits only
      end
    end
  end

  assign o_spi_mux     = scratch_reg[2:0];
  assign o_cpld_reset  = scratch_reg[3];
  assign o_route_table = route_tbl;

  ////////////////////////////////////////////////////////////
  // read decode and merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_glob_hit  = 1'b1;
    rd_glob_data = '0;
    case (i_reg_rd.addr)
      reg_addr_t'(`REG_GIT_HASH): rd_glob_data = reg_data_t'(`CORE_GIT_HASH);
      reg_addr_t'(`REG_NUM_CE):   rd_glob_data = reg_data_t'(`CORE_NUM_CE);
      reg_addr_t'(`REG_SCRATCH):  rd_glob_data = scratch_reg;
      default:                    rd_glob_hit  = 1'b0;  // not a global word
    endcase
  end

  assign rd_xbar_hit  = xbar_hit(i_reg_rd.addr);
  assign rd_xbar_data = reg_data_t'(route_tbl[xbar_row(i_reg_rd.addr)]);  // zero extended

  // unknown address gives no pulse at all
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_resp_q <= 1'b0;
    end else begin
      rd_resp_q <= i_reg_rd.rd_req && (rd_glob_hit || rd_xbar_hit);
    end
  end

  // windows never overlap so the OR merge is safe
  always_ff @(posedge bus_clk) begin
    if (i_reg_rd.rd_req) begin
      rd_data_q <= (rd_glob_hit ? rd_glob_data : '0) | (rd_xbar_hit ? rd_xbar_data : '0);
    end
  end

  assign o_reg_rd_resp.resp = rd_resp_q;
  assign o_reg_rd_resp.data = rd_data_q;

  // response pulse lasts one cycle
  a_resp_single : assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_reg_rd_resp.resp |=> !o_reg_rd_resp.resp)
    else $error("read response held two cycles");

endmodule

`default_nettype wire

/* logic/xbar_in_port.sv */
// crossbar input port that routes each packet by its header and holds the route
`default_nettype none

module xbar_in_port
  import core_stream_pkg::*;
(
  input  logic         bus_clk,
  input  logic         bus_rst,
  input  stream_t      i_stream,       // upstream beats
  output logic         o_tready,       // back to upstream
  input  route_table_t i_route_table,  // from core_ctrl
  output port_mask_t   o_req,          // one bit per output
  input  port_mask_t   i_grant,        // bit o set when output o grants us
  input  port_mask_t   i_out_ready     // tready of every output
);

  in_state_e  state;
  port_idx_t  route_q;     // output for the packet in flight
  route_idx_t hdr_idx;     // dest nibble of the current beat
  logic       pkt_done;    // tlast beat accepted

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // only the granting output can let a beat through
  assign o_tready = |(i_grant & i_out_ready);
  assign pkt_done = i_stream.tvalid && o_tready && i_stream.tlast;

  // header beat is held while idle so its dest field is still on the bus
  assign hdr_idx = i_stream.tdata[$bits(route_idx_t)-1:0];

  ////////////////////////////////////////////////////////////
  // route FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (i_stream.tvalid) begin
            state <= ROUTED;  // header seen
          end
        end
        ROUTED: begin
          if (pkt_done) begin
            state <= IDLE;    // free for the next header
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // table lookup on the header beat
  always_ff @(posedge bus_clk) begin
    if (state == IDLE && i_stream.tvalid) begin
      route_q <= i_route_table[hdr_idx];
    end
  end

  // request stays up until tlast passes
  assign o_req = (state == ROUTED) ? (port_mask_t'(1) << route_q) : '0;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_req_onehot : assert property (@(posedge bus_clk) disable iff (bus_rst)
    $onehot0(o_req))
    else $error("input port requests more than one output");

  // grant from the arbiters must track our own request
  a_grant_in_req : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (i_grant & ~o_req) == '0)
    else $error("granted by an output that was not requested");

endmodule

`default_nettype wire

/* logic/xbar_out_arb.sv */
// crossbar output port with round robin arbitration locked per packet
`default_nettype none

`include "core_consts.svh"

module xbar_out_arb
  import core_stream_pkg::*;
(
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  input  port_mask_t                     i_req,       // bit p from input p
  input  stream_t [`CORE_NUM_PORTS-1:0]  i_streams,   // all inputs
  input  logic                           i_tready,    // downstream ready
  output stream_t                        o_stream,
  output port_mask_t                     o_grant      // bit p granted to input p
);

  localparam int NP = `CORE_NUM_PORTS;

  port_mask_t grant_q;    // zero when the output is free
  port_idx_t  last_q;     // last granted input, also the mux select
  logic       pick_vld;
  port_idx_t  pick_idx;   // next winner
  logic       pkt_done;   // tlast leaves the output

  ////////////////////////////////////////////////////////////
  // round robin pick
  ////////////////////////////////////////////////////////////

  // search starts just after the last winner and wraps
  always_comb begin : rr_pick
    port_idx_t cand;
    pick_vld = 1'b0;
    pick_idx = last_q;
    for (int i = 1; i <= NP; i++) begin
      cand = last_q + port_idx_t'(i);  // wraps at NP, last winner checked last
      if (!pick_vld && i_req[cand]) begin
        pick_vld = 1'b1;
        pick_idx = cand;
      end
    end
  end

  assign pkt_done = o_stream.tvalid && i_tready && o_stream.tlast;

  ////////////////////////////////////////////////////////////
  // grant and lock
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      grant_q <= '0;
      last_q  <= port_idx_t'(NP - 1);  // input 0 wins first
    end else if (grant_q == '0) begin
      if (pick_vld) begin
        grant_q <= port_mask_t'(1) << pick_idx;
        last_q  <= pick_idx;
      end
    end else if (pkt_done) begin
      grant_q <= '0;                   // unlock after the last beat
    end
  end

  assign o_grant = grant_q;

  // data path steered by the locked input
  assign o_stream = (grant_q != '0) ? i_streams[last_q] : '0;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_grant_onehot : assert property (@(posedge bus_clk) disable iff (bus_rst)
    $onehot0(o_grant))
    else $error("output grants more than one input");

  // back-pressure reaches the held input so the beat cannot move
  a_hold_stable : assert property (@(posedge bus_clk) disable iff (bus_rst)
    (o_stream.tvalid && !i_tready) |=>
      (o_stream.tvalid && $stable(o_stream.tdata) && $stable(o_stream.tlast)))
    else $error("output beat changed under back-pressure");

endmodule

`default_nettype wire

/* logic/core_top.sv */
// bus clock core with register port, routing control and a 4x4 packet crossbar
`default_nettype none

`include "core_consts.svh"

module core_top
  import core_reg_pkg::*;
  import core_stream_pkg::*;
(
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  // register port
  input  reg_wr_t                        i_reg_wr,
  input  reg_rd_req_t                    i_reg_rd,
  output reg_rd_resp_t                   o_reg_rd_resp,
  // streams in, eth0 eth1 dma ce0
  input  stream_t [`CORE_NUM_PORTS-1:0]  i_streams,
  output port_mask_t                     o_in_tready,
  // streams out, same order
  output stream_t [`CORE_NUM_PORTS-1:0]  o_streams,
  input  port_mask_t                     i_out_tready,
  // board controls from scratch
  output logic [2:0]                     o_spi_mux,
  output logic                           o_cpld_reset
);

  localparam int NP = `CORE_NUM_PORTS;

  route_table_t            route_tbl;
  port_mask_t [NP-1:0]     in_req;     // [input][output]
  port_mask_t [NP-1:0]     arb_req;    // [output][input]
  port_mask_t [NP-1:0]     arb_grant;  // [output][input]
  port_mask_t [NP-1:0]     in_grant;   // [input][output]

  ////////////////////////////////////////////////////////////
  // registers and routing table
  ////////////////////////////////////////////////////////////

  core_ctrl i_core_ctrl (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_reg_wr      (i_reg_wr),
    .i_reg_rd      (i_reg_rd),
    .o_reg_rd_resp (o_reg_rd_resp),
    .o_route_table (route_tbl),
    .o_spi_mux     (o_spi_mux),
    .o_cpld_reset  (o_cpld_reset)
  );

  ////////////////////////////////////////////////////////////
  // crossbar
  ////////////////////////////////////////////////////////////

  // request and grant matrices flip between input and output view
  for (genvar o = 0; o < NP; o++) begin : g_xpose_o
    for (genvar p = 0; p < NP; p++) begin : g_xpose_p
      assign arb_req[o][p]  = in_req[p][o];
      assign in_grant[p][o] = arb_grant[o][p];
    end
  end

  for (genvar p = 0; p < NP; p++) begin : g_in
    xbar_in_port i_xbar_in_port (
      .bus_clk       (bus_clk),
      .bus_rst       (bus_rst),
      .i_stream      (i_streams[p]),
      .o_tready      (o_in_tready[p]),
      .i_route_table (route_tbl),
      .o_req         (in_req[p]),
      .i_grant       (in_grant[p]),
      .i_out_ready   (i_out_tready)
    );
  end

  for (genvar o = 0; o < NP; o++) begin : g_out
    xbar_out_arb i_xbar_out_arb (
      .bus_clk   (bus_clk),
      .bus_rst   (bus_rst),
      .i_req     (arb_req[o]),
      .i_streams (i_streams),
      .i_tready  (i_out_tready[o]),
      .o_stream  (o_streams[o]),
      .o_grant   (arb_grant[o])
    );
  end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
// testbench clock source with a reset held for the first two cycles
`default_nettype none

module tb_clk_gen (
  output logic o_clk,   // period 10
  output logic o_rst    // high for 2 rising edges
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
// scoreboard that models register reads, routes and stream beats of the core
`default_nettype none

`include "core_consts.svh"

module tb_checker
  import core_reg_pkg::*;
  import core_stream_pkg::*;
(
  input  wire logic                          bus_clk,
  input  wire logic                          bus_rst,
  input  wire reg_wr_t                       i_reg_wr,
  input  wire reg_rd_req_t                   i_reg_rd,
  input  wire reg_rd_resp_t                  i_rd_resp,
  input  wire logic                          i_exp_hit,     // read expects a response
  input  wire reg_data_t                     i_exp_data,
  input  wire stream_t [`CORE_NUM_PORTS-1:0] i_in_streams,
  input  wire port_mask_t                    i_in_tready,
  input  wire stream_t [`CORE_NUM_PORTS-1:0] i_out_streams,
  input  wire port_mask_t                    i_out_tready,
  input  wire logic [2:0]                    i_spi_mux,
  input  wire logic                          i_cpld_reset,
  output int                                 o_err_cnt,
  output int                                 o_beats,       // beats compared
  output int                                 o_reads,       // responses compared
  output int                                 o_pending      // beats still expected
);

  localparam int NP = `CORE_NUM_PORTS;

  logic [64:0] exp_q [NP*NP][$];   // {tlast, tdata} queued per input*NP + output
  port_idx_t   route_m [`CORE_ROUTE_ENTRIES];
  reg_data_t   scr_m;              // scratch model
  logic        in_pkt [NP];        // input is inside a packet
  port_idx_t   in_dst [NP];        // output picked by the header
  logic        out_busy [NP];
  port_idx_t   out_src [NP];       // input owning the output packet
  logic        rd_pend;
  reg_data_t   rd_exp;

  initial begin
    o_err_cnt = 0;
    o_beats   = 0;
    o_reads   = 0;
    rd_pend   = 1'b0;
    rd_exp    = '0;
  end

  always @(posedge bus_clk) begin : watch
    port_idx_t src;
    logic [64:0] exp;
    logic rdy_exp;
    int tot;
    if (bus_rst) begin
      scr_m = reg_data_t'(`SCRATCH_RESET);
      for (int k = 0; k < `CORE_ROUTE_ENTRIES; k++) route_m[k] = port_idx_t'(k % NP);
      for (int k = 0; k < NP; k++) begin
        in_pkt[k]   = 1'b0;
        out_busy[k] = 1'b0;
      end
      rd_pend = 1'b0;
    end else begin
      /////////////////////////////////////////////////////////////
      // register side
      /////////////////////////////////////////////////////////////
      if (i_spi_mux !== scr_m[2:0]) begin
        $display("[FAIL] t=%0t o_spi_mux: got %h exp %h", $time, i_spi_mux, scr_m[2:0]);
        o_err_cnt++;
      end
      if (i_cpld_reset !== scr_m[3]) begin
        $display("[FAIL] t=%0t o_cpld_reset: got %h exp %h", $time, i_cpld_reset, scr_m[3]);
        o_err_cnt++;
      end
      if (rd_pend) begin
        o_reads++;
        if (i_rd_resp.resp !== 1'b1) begin
          $display("t=%0t read response missing one cycle after the strobe", $time);
          o_err_cnt++;
        end else if (i_rd_resp.data !== rd_exp) begin
          $display("[FAIL] t=%0t o_reg_rd_resp.data: got %h exp %h", $time,
                   i_rd_resp.data, rd_exp);
          o_err_cnt++;
        end
      end else if (i_rd_resp.resp !== 1'b0) begin
        $display("t=%0t read response appeared with no read to answer", $time);
        o_err_cnt++;
      end
      rd_pend = i_reg_rd.rd_req && i_exp_hit;
      rd_exp  = i_exp_data;
      if (i_reg_wr.wr_req) begin   // same edge as the DUT
        if (i_reg_wr.addr == reg_addr_t'(`REG_SCRATCH)) scr_m = i_reg_wr.data;
        if (i_reg_wr.addr >= reg_addr_t'(`REG_XBAR_BASE) &&
            i_reg_wr.addr < reg_addr_t'(`REG_XBAR_BASE + 4 * `CORE_ROUTE_ENTRIES) &&
            i_reg_wr.addr[1:0] == 2'b00) begin
          route_m[route_idx_t'((i_reg_wr.addr - reg_addr_t'(`REG_XBAR_BASE)) >> 2)] =
            port_idx_t'(i_reg_wr.data[1:0]);
        end
      end
      /////////////////////////////////////////////////////////////
      // input ready follows the output that holds the packet
      /////////////////////////////////////////////////////////////
      for (int p = 0; p < NP; p++) begin
        if (in_pkt[p]) begin
          rdy_exp = i_out_tready[in_dst[p]];  // locked until tlast
          if (i_in_tready[p] !== rdy_exp) begin
            $display("[FAIL] t=%0t o_in_tready[%0d]: got %h exp %h", $time, p,
                     i_in_tready[p], rdy_exp);
            o_err_cnt++;
          end
        end else if (i_in_tready[p] === 1'b1 && !(i_in_streams[p].tvalid &&
                     i_out_tready[route_m[i_in_streams[p].tdata[3:0]]])) begin
          $display("t=%0t input %0d ready with no output able to take its header",
                   $time, p);
          o_err_cnt++;
        end
      end
      /////////////////////////////////////////////////////////////
      // accepted input beats become expected output beats
      /////////////////////////////////////////////////////////////
      for (int p = 0; p < NP; p++) begin
        if (i_in_streams[p].tvalid && i_in_tready[p]) begin
          if (!in_pkt[p]) in_dst[p] = route_m[i_in_streams[p].tdata[3:0]];  // header
          exp_q[p*NP + int'(in_dst[p])].push_back({i_in_streams[p].tlast,
                                                   i_in_streams[p].tdata});
          in_pkt[p] = !i_in_streams[p].tlast;
        end
      end
      // output beats against the queues
      for (int o = 0; o < NP; o++) begin
        if (i_out_streams[o].tvalid && i_out_tready[o]) begin
          src = port_idx_t'(i_out_streams[o].tdata[49:48]);  // input number field
          if (out_busy[o] && src != out_src[o]) begin
            $display("t=%0t output %0d mixed input %0d into a packet of input %0d",
                     $time, o, src, out_src[o]);
            o_err_cnt++;
          end
          if (exp_q[int'(src)*NP + o].size() == 0) begin
            $display("t=%0t output %0d sent a beat that was never expected there", $time, o);
            o_err_cnt++;
          end else begin
            exp = exp_q[int'(src)*NP + o].pop_front();
            o_beats++;
            if ({i_out_streams[o].tlast, i_out_streams[o].tdata} !== exp) begin
              $display("[FAIL] t=%0t o_streams[%0d]: got %h exp %h", $time, o,
                       {i_out_streams[o].tlast, i_out_streams[o].tdata}, exp);
              o_err_cnt++;
            end
          end
          out_busy[o] = !i_out_streams[o].tlast;
          out_src[o]  = src;
        end
      end
    end
    tot = 0;
    for (int k = 0; k < NP*NP; k++) tot += exp_q[k].size();
    o_pending = tot;
  end

endmodule

`default_nettype wire

/* bench/tb_core.sv */
// testbench top for the bus clock core that applies a step table to the register port and streams
`default_nettype none

`include "core_consts.svh"

module tb_core;
  import core_reg_pkg::*;
  import core_stream_pkg::*;

  localparam int NP = `CORE_NUM_PORTS;
  localparam logic [2:0] OP_WR      = 3'd0;
  localparam logic [2:0] OP_RD      = 3'd1;
  localparam logic [2:0] OP_RD_NONE = 3'd2;
  localparam logic [2:0] OP_PKT     = 3'd3;
  localparam logic [2:0] OP_DRAIN   = 3'd4;

  typedef struct packed {
    logic [2:0]  op;
    logic [13:0] addr;
    logic [31:0] data;   // write data or expected read data
    logic [1:0]  port;   // input for a packet
    logic [15:0] dest;
    logic [7:0]  len;
  } step_t;

  wire logic bus_clk;
  wire logic bus_rst;
  reg_wr_t      reg_wr;
  reg_rd_req_t  reg_rd;
  reg_rd_resp_t rd_resp;
  logic         exp_hit;
  reg_data_t    exp_data;
  wire stream_t [NP-1:0] in_streams;
  port_mask_t   in_tready;
  stream_t [NP-1:0] out_streams;
  port_mask_t   out_tready;
  logic [2:0]   spi_mux;
  logic         cpld_reset;
  int err_cnt;
  int beats;
  int reads;
  int pending;
  int pkt_q [NP][$];          // {dest, len} per input
  logic drv_busy [NP];
  step_t steps[$];
  int limit = 1000000;
  int cycles = 0;

  tb_clk_gen i_tb_clk_gen (.o_clk(bus_clk), .o_rst(bus_rst));

  core_top i_core_top (
    .bus_clk(bus_clk), .bus_rst(bus_rst), .i_reg_wr(reg_wr), .i_reg_rd(reg_rd),
    .o_reg_rd_resp(rd_resp), .i_streams(in_streams), .o_in_tready(in_tready),
    .o_streams(out_streams), .i_out_tready(out_tready), .o_spi_mux(spi_mux),
    .o_cpld_reset(cpld_reset)
  );

  tb_checker i_tb_checker (
    .bus_clk(bus_clk), .bus_rst(bus_rst), .i_reg_wr(reg_wr), .i_reg_rd(reg_rd),
    .i_rd_resp(rd_resp), .i_exp_hit(exp_hit), .i_exp_data(exp_data),
    .i_in_streams(in_streams), .i_in_tready(in_tready), .i_out_streams(out_streams),
    .i_out_tready(out_tready), .i_spi_mux(spi_mux), .i_cpld_reset(cpld_reset),
    .o_err_cnt(err_cnt), .o_beats(beats), .o_reads(reads), .o_pending(pending)
  );

  ////////////////////////////////////////////////////////////
  // per-input packet drivers
  ////////////////////////////////////////////////////////////
  for (genvar p = 0; p < NP; p++) begin : g_drv
    stream_t s;
    assign in_streams[p] = s;
    initial begin : drive
      int desc, beat, len, seq;
      logic took;
      logic [15:0] dst;
      s = '0;
      beat = 0;
      len = 0;
      seq = 0;
      dst = '0;
      drv_busy[p] = 1'b0;
      forever begin
        @(posedge bus_clk);
        took = s.tvalid && in_tready[p];
        #1;
        if (took) beat++;
        if (beat >= len) begin         // nothing in flight
          s = '0;
          if (pkt_q[p].size() > 0) begin
            desc = pkt_q[p].pop_front();
            dst  = desc[23:8];
            len  = int'(desc[7:0]);
            beat = 0;
            seq++;
          end
        end
        if (beat < len) begin
          s.tvalid = 1'b1;
          s.tlast  = (beat == len - 1);
          s.tdata  = {16'(p), 16'(seq), 16'(beat), dst};  // identifies every beat
        end
        drv_busy[p] = (beat < len) || (pkt_q[p].size() > 0);
      end
    end
  end

  // each output ready is high 3 cycles in 4 on average
  initial begin : ready_rand
    logic [31:0] r;
    void'($urandom(32'h062a_3ef1));
    forever begin
      @(posedge bus_clk);
      #1;
      r = $urandom;
      out_tready = ~(r[3:0] & r[7:4]);
    end
  end

  always @(posedge bus_clk) begin : watchdog
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run passed %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic step_t make_step(logic [2:0] op, int addr, logic [31:0] data,
                                      int port, int dest, int len);
    step_t st;
    st = '{op, 14'(addr), data, 2'(port), 16'(dest), 8'(len)};
    return st;
  endfunction

  function automatic logic drivers_idle();
    logic idle;
    idle = 1'b1;
    for (int p = 0; p < NP; p++) begin
      if (drv_busy[p] || pkt_q[p].size() > 0) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic write_reg(logic [13:0] addr, logic [31:0] data);
    @(posedge bus_clk); #1;
    reg_wr = '{1'b1, addr, data};
    @(posedge bus_clk); #1;
    reg_wr.wr_req = 1'b0;
  endtask

  task automatic read_reg(logic [13:0] addr, logic hit, logic [31:0] exp);
    @(posedge bus_clk); #1;
    reg_rd   = '{1'b1, addr};
    exp_hit  = hit;
    exp_data = exp;
    @(posedge bus_clk); #1;
    reg_rd.rd_req = 1'b0;
    exp_hit       = 1'b0;
    repeat (4) @(posedge bus_clk);  // window for a stray response
  endtask

  // counters are read once the checker and drivers have settled
  task automatic wait_drain();
    while (!(drivers_idle() && pending == 0)) begin
      @(posedge bus_clk);
      #2;
    end
    repeat (4) @(posedge bus_clk);
    #2;
  endtask

  initial begin : run
    int total;
    reg_wr     = '0;
    reg_rd     = '0;
    exp_hit    = 1'b0;
    exp_data   = '0;
    out_tready = '1;
    // reset values and global words
    steps.push_back(make_step(OP_RD, `REG_SCRATCH, 32'h2, 0, 0, 0));
    steps.push_back(make_step(OP_WR, `REG_SCRATCH, 32'h0000_000d, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_SCRATCH, 32'h0000_000d, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_GIT_HASH, `CORE_GIT_HASH, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_NUM_CE, `CORE_NUM_CE, 0, 0, 0));
    steps.push_back(make_step(OP_RD_NONE, 'h100, 0, 0, 0, 0));
    steps.push_back(make_step(OP_RD_NONE, 'h0c, 0, 0, 0, 0));
    // default routes send nibble mod 4
    steps.push_back(make_step(OP_PKT, 0, 0, 0, 'h0001, 4));
    steps.push_back(make_step(OP_PKT, 0, 0, 1, 'h0002, 3));
    steps.push_back(make_step(OP_PKT, 0, 0, 2, 'h0003, 5));
    steps.push_back(make_step(OP_PKT, 0, 0, 3, 'h0004, 2));
    steps.push_back(make_step(OP_PKT, 0, 0, 0, 'h0005, 1));
    steps.push_back(make_step(OP_PKT, 0, 0, 0, 'h00a6, 3));
    steps.push_back(make_step(OP_DRAIN, 0, 0, 0, 0, 0));
    // new routes send rows 1 and 2 to port 3 and row 3 to port 2
    steps.push_back(make_step(OP_WR, `REG_XBAR_BASE + 4, 32'h3, 0, 0, 0));
    steps.push_back(make_step(OP_WR, `REG_XBAR_BASE + 8, 32'h3, 0, 0, 0));
    steps.push_back(make_step(OP_WR, `REG_XBAR_BASE + 12, 32'h6, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_XBAR_BASE + 4, 32'h3, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_XBAR_BASE + 8, 32'h3, 0, 0, 0));
    steps.push_back(make_step(OP_RD, `REG_XBAR_BASE + 12, 32'h2, 0, 0, 0));
    steps.push_back(make_step(OP_PKT, 0, 0, 0, 'h0001, 6));
    steps.push_back(make_step(OP_PKT, 0, 0, 1, 'h0002, 5));
    steps.push_back(make_step(OP_PKT, 0, 0, 2, 'h0013, 4));
    steps.push_back(make_step(OP_PKT, 0, 0, 3, 'h0003, 3));
    steps.push_back(make_step(OP_PKT, 0, 0, 0, 'h0000, 2));
    steps.push_back(make_step(OP_PKT, 0, 0, 1, 'h0001, 7));
    steps.push_back(make_step(OP_DRAIN, 0, 0, 0, 0, 0));
    total = 0;
    foreach (steps[i]) total += (steps[i].op == OP_PKT) ? int'(steps[i].len) : 1;
    limit = 20 * total + 200;
    wait (bus_rst == 1'b0);
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR:      write_reg(steps[i].addr, steps[i].data);
        OP_RD:      read_reg(steps[i].addr, 1'b1, steps[i].data);
        OP_RD_NONE: read_reg(steps[i].addr, 1'b0, '0);
        OP_PKT:     pkt_q[steps[i].port].push_back(int'({steps[i].dest, steps[i].len}));
        default:    wait_drain();
      endcase
    end
    $display("errors %0d, beats checked %0d, reads checked %0d, beats left %0d",
             err_cnt, beats, reads, pending);
    if (err_cnt == 0 && pending == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
logic/core_reg_pkg.sv
logic/core_stream_pkg.sv
logic/core_ctrl.sv
logic/xbar_in_port.sv
logic/xbar_out_arb.sv
logic/core_top.sv
bench/tb_clk_gen.sv
bench/tb_checker.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_core \
  -f flist.f

./obj_dir/Vtb_core > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
